/* Makefile */
# Verilator simulation of the food-delivery controller

VERILATOR ?= verilator
TOP       ?= fd_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)

.PHONY: sim clean

# pass or fail is taken from the log, not from the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
+incdir+source
source/fd_cmd_pkg.sv
source/fd_dram_pkg.sv
source/fd_mem_if.sv
source/fd_update.sv
source/fd_dram_access.sv
source/fd_ctrl.sv
source/fd_top.sv
verif/fd_checker.sv
verif/fd_tb.sv

/* source/fd_cmd_pkg.sv */
`include "fd_defs.svh"

package fd_cmd_pkg;

    // ================================================
    // command side
    // ================================================
    typedef enum logic [1:0] {
        Deliver   = 2'd0,
        Order     = 2'd1,
        Cancel    = 2'd2,
        No_action = 2'd3
    } action_e;

    typedef enum logic [3:0] {
        No_Err        = 4'd0,
        Res_busy      = 4'd2,
        No_customers  = 4'd3,
        Wrong_cancel  = 4'd4,
        Wrong_res_ID  = 4'd5,
        Wrong_food_ID = 4'd6
    } err_e;

    // low bits of data_in on food_valid
    typedef struct packed {
        logic [1:0]           food_id;
        logic [`FD_SER_W-1:0] servings;
    } food_ser_t;

    typedef struct packed {
        logic [`FD_ID_W-1:0] d_man_id;
        logic [`FD_ID_W-1:0] res_id;
        food_ser_t           food_ser;
    } cmd_t;

endpackage

/* source/fd_ctrl.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_ctrl (
    input  logic                 clk,
    input  logic                 inf_rst_n,
    input  logic                 act_valid,
    input  logic                 id_valid,
    input  logic                 res_valid,
    input  logic                 food_valid,
    input  logic [`FD_BUS_W-1:0] data_in,
    fd_mem_if.ctrl               mem,
    output logic                 upd_start,
    output fd_cmd_pkg::action_e  action,
    output fd_cmd_pkg::cmd_t     cmd,
    output fd_dram_pkg::record_t rec,
    input  logic                 upd_done,
    input  fd_cmd_pkg::err_e     upd_err,
    input  fd_dram_pkg::record_t upd_rec,
    output logic                 out_valid,
    output logic                 complete,
    output fd_cmd_pkg::err_e     err_msg,
    output logic [`FD_RAW_W-1:0] out_info
);
    import fd_cmd_pkg::*;
    import fd_dram_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INPUT,
        S_READ,
        S_UPD,
        S_WRITE,
        S_OUT
    } state_e;

    state_e                state;
    state_e                nxt_state;
    logic                  trigger;
    logic                  upd_ok;
    logic                  upd_bad;
    logic [`FD_RAW_W-1:0]  result_info;

    // last pulse of each command sequence
    assign trigger = (state == S_INPUT) &&
                     (((action == Order) && food_valid) ||
                      ((action == Deliver || action == Cancel) && id_valid));

    assign upd_ok  = (state == S_UPD) && upd_done && (upd_err == No_Err);
    assign upd_bad = (state == S_UPD) && upd_done && (upd_err != No_Err);

    // ================================================
    // input capture
    // ================================================
    always_ff @(posedge clk) begin
        if (id_valid)
            cmd.d_man_id <= data_in[`FD_ID_W-1:0];
        if (res_valid)
            cmd.res_id <= data_in[`FD_ID_W-1:0];
        if (food_valid)
            cmd.food_ser <= food_ser_t'(data_in[$bits(food_ser_t)-1:0]);
        // record from DRAM, then the updated copy
        if ((state == S_READ) && mem.done)
            rec <= mem.rdata;
        else if (upd_ok)
            rec <= upd_rec;
    end

    // ================================================
    // FSM and request pulses
    // ================================================
    always_comb begin
        nxt_state = state;
        case (state)
            S_IDLE:  if (act_valid) nxt_state = S_INPUT;
            S_INPUT: if (trigger) nxt_state = S_READ;
            S_READ:  if (mem.done) nxt_state = S_UPD;
            S_UPD: begin
                if (upd_ok)
                    nxt_state = S_WRITE;
                else if (upd_bad)
                    nxt_state = S_OUT;
            end
            S_WRITE: if (mem.done) nxt_state = S_OUT;
            S_OUT:   nxt_state = act_valid ? S_INPUT : S_IDLE;
            default: nxt_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge inf_rst_n) begin
        if (!inf_rst_n) begin
            state     <= S_IDLE;
            action    <= No_action;
            mem.req   <= 1'b0;
            upd_start <= 1'b0;
        end else begin
            state <= nxt_state;
            if (act_valid)
                action <= action_e'(data_in[$bits(action_e)-1:0]);
            // read after trigger, write after a clean update
            mem.req   <= trigger || upd_ok;
            upd_start <= (state == S_READ) && mem.done;
        end
    end

    assign mem.wr    = (state == S_WRITE);
    assign mem.addr  = (action == Order) ? cmd.res_id : cmd.d_man_id;
    assign mem.wdata = rec;

    // ================================================
    // result
    // ================================================
    assign result_info = (action == Order) ?
                         {{$bits(d_man_t){1'b0}}, rec.res} :
                         {rec.d_man, {$bits(res_info_t){1'b0}}};

    always_ff @(posedge clk or negedge inf_rst_n) begin
        if (!inf_rst_n) begin
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= No_Err;
            out_info  <= '0;
        end else if (upd_bad) begin
            out_valid <= 1'b1;
            complete  <= 1'b0;
            err_msg   <= upd_err;
            out_info  <= '0;
        end else if ((state == S_WRITE) && mem.done) begin
            out_valid <= 1'b1;
            complete  <= 1'b1;
            err_msg   <= No_Err;
            out_info  <= result_info;
        end else begin
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= No_Err;
            out_info  <= '0;
        end
    end

endmodule

/* source/fd_defs.svh */
`ifndef FD_DEFS_SVH
`define FD_DEFS_SVH

// shared input bus
`define FD_BUS_W  8

// delivery man and restaurant ids
`define FD_ID_W   8

// servings field of a food entry
`define FD_SER_W  4

// external DRAM word and address
`define FD_RAW_W  64
`define FD_ADDR_W 8

// stock sum, wide enough for three foods plus new servings
`define FD_SUM_W  10

`endif

/* source/fd_dram_access.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_dram_access (
    input  logic                  clk,
    input  logic                  inf_rst_n,
    fd_mem_if.port                mem,
    output logic [`FD_ADDR_W-1:0] c_addr,
    output logic [`FD_RAW_W-1:0]  c_data_w,
    output logic                  c_in_valid,
    output logic                  c_r_wb,
    input  logic [`FD_RAW_W-1:0]  c_data_r,
    input  logic                  c_out_valid
);
    import fd_dram_pkg::*;

    // customer bytes are stored swapped, the same swap undoes it
    function automatic logic [15:0] swap16(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    function automatic logic [`FD_RAW_W-1:0] pack(input record_t r);
        return {swap16(r.d_man.ctm2), swap16(r.d_man.ctm1),
                r.res.food3, r.res.food2, r.res.food1, r.res.limit};
    endfunction

    function automatic record_t unpack(input logic [`FD_RAW_W-1:0] raw);
        record_t r;
        r.d_man.ctm1 = ctm_info_t'(swap16(raw[47:32]));
        r.d_man.ctm2 = ctm_info_t'(swap16(raw[63:48]));
        r.res.limit  = raw[7:0];
        r.res.food1  = raw[15:8];
        r.res.food2  = raw[23:16];
        r.res.food3  = raw[31:24];
        return r;
    endfunction

    // ================================================
    // request towards DRAM
    // ================================================
    always_ff @(posedge clk or negedge inf_rst_n) begin
        if (!inf_rst_n) begin
            c_in_valid <= 1'b0;
            c_r_wb     <= 1'b1;
            c_addr     <= '0;
            mem.done   <= 1'b0;
        end else begin
            c_in_valid <= mem.req;
            mem.done   <= c_out_valid;
            // bus held until the next request
            if (mem.req) begin
                c_r_wb <= ~mem.wr;
                c_addr <= mem.addr;
            end
        end
    end

    // write data and read capture
    always_ff @(posedge clk) begin
        if (mem.req)
            c_data_w <= pack(mem.wdata);
        if (c_out_valid)
            mem.rdata <= unpack(c_data_r);
    end

endmodule

/* source/fd_dram_pkg.sv */
`include "fd_defs.svh"

package fd_dram_pkg;

    // ================================================
    // DRAM record
    // ================================================

    // all zero means an empty slot
    typedef struct packed {
        logic [1:0]           status;
        logic [`FD_ID_W-1:0]  res_id;
        logic [1:0]           food_id;
        logic [`FD_SER_W-1:0] servings;
    } ctm_info_t;

    typedef struct packed {
        ctm_info_t ctm1;
        ctm_info_t ctm2;
    } d_man_t;

    typedef struct packed {
        logic [7:0] limit;
        logic [7:0] food1;
        logic [7:0] food2;
        logic [7:0] food3;
    } res_info_t;

    typedef struct packed {
        d_man_t    d_man;
        res_info_t res;
    } record_t;

endpackage

/* source/fd_mem_if.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

interface fd_mem_if;
    import fd_dram_pkg::*;

    // request side, req is a single cycle pulse
    logic                  req;
    logic                  wr;
    logic [`FD_ADDR_W-1:0] addr;
    record_t               wdata;

    // completion, rdata valid with done on reads
    logic                  done;
    record_t               rdata;

    modport ctrl (
        output req, wr, addr, wdata,
        input  done, rdata
    );

    modport port (
        input  req, wr, addr, wdata,
        output done, rdata
    );

endinterface

/* source/fd_top.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_top (
    input  logic                  clk,
    input  logic                  inf_rst_n,
    input  logic                  act_valid,
    input  logic                  id_valid,
    input  logic                  res_valid,
    input  logic                  food_valid,
    input  logic [`FD_BUS_W-1:0]  data_in,
    input  logic [`FD_RAW_W-1:0]  c_data_r,
    input  logic                  c_out_valid,
    output logic [`FD_ADDR_W-1:0] c_addr,
    output logic [`FD_RAW_W-1:0]  c_data_w,
    output logic                  c_in_valid,
    output logic                  c_r_wb,
    output logic                  out_valid,
    output logic                  complete,
    output fd_cmd_pkg::err_e      err_msg,
    output logic [`FD_RAW_W-1:0]  out_info
);
    import fd_cmd_pkg::*;
    import fd_dram_pkg::*;

    logic    upd_start;
    logic    upd_done;
    action_e action;
    cmd_t    cmd;
    record_t rec;
    err_e    upd_err;
    record_t upd_rec;

    fd_mem_if mem_if ();

    fd_ctrl i_ctrl (
        .clk        (clk),
        .inf_rst_n  (inf_rst_n),
        .act_valid  (act_valid),
        .id_valid   (id_valid),
        .res_valid  (res_valid),
        .food_valid (food_valid),
        .data_in    (data_in),
        .mem        (mem_if),
        .upd_start  (upd_start),
        .action     (action),
        .cmd        (cmd),
        .rec        (rec),
        .upd_done   (upd_done),
        .upd_err    (upd_err),
        .upd_rec    (upd_rec),
        .out_valid  (out_valid),
        .complete   (complete),
        .err_msg    (err_msg),
        .out_info   (out_info)
    );

    // two cycle check and record update
    fd_update i_update (
        .clk       (clk),
        .inf_rst_n (inf_rst_n),
        .start     (upd_start),
        .action    (action),
        .cmd       (cmd),
        .rec       (rec),
        .done      (upd_done),
        .err       (upd_err),
        .new_rec   (upd_rec)
    );

    fd_dram_access i_dram_access (
        .clk         (clk),
        .inf_rst_n   (inf_rst_n),
        .mem         (mem_if),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .c_data_r    (c_data_r),
        .c_out_valid (c_out_valid)
    );

endmodule

/* source/fd_update.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_update (
    input  logic                 clk,
    input  logic                 inf_rst_n,
    input  logic                 start,
    input  fd_cmd_pkg::action_e  action,
    input  fd_cmd_pkg::cmd_t     cmd,
    input  fd_dram_pkg::record_t rec,
    output logic                 done,
    output fd_cmd_pkg::err_e     err,
    output fd_dram_pkg::record_t new_rec
);
    import fd_cmd_pkg::*;
    import fd_dram_pkg::*;

    typedef logic [`FD_SUM_W-1:0] sum_t;

    logic      stage1;
    logic      res_hit1;
    logic      res_hit2;
    logic      food_hit1;
    logic      food_hit2;
    sum_t      sum;
    err_e      nxt_err;
    record_t   nxt_rec;
    ctm_info_t keep1;
    ctm_info_t keep2;

    always_ff @(posedge clk or negedge inf_rst_n) begin
        if (!inf_rst_n) begin
            stage1 <= 1'b0;
            done   <= 1'b0;
        end else begin
            stage1 <= start;
            done   <= stage1;
        end
    end

    // ================================================
    // cycle 1, match flags and stock sum
    // ================================================
    always_ff @(posedge clk) begin
        if (start) begin
            res_hit1  <= (rec.d_man.ctm1 != '0) && (rec.d_man.ctm1.res_id == cmd.res_id);
            res_hit2  <= (rec.d_man.ctm2 != '0) && (rec.d_man.ctm2.res_id == cmd.res_id);
            food_hit1 <= (rec.d_man.ctm1 != '0) && (rec.d_man.ctm1.res_id == cmd.res_id)
                         && (rec.d_man.ctm1.food_id == cmd.food_ser.food_id);
            food_hit2 <= (rec.d_man.ctm2 != '0) && (rec.d_man.ctm2.res_id == cmd.res_id)
                         && (rec.d_man.ctm2.food_id == cmd.food_ser.food_id);
            sum       <= sum_t'(rec.res.food1) + sum_t'(rec.res.food2)
                         + sum_t'(rec.res.food3) + sum_t'(cmd.food_ser.servings);
        end
    end

    // ================================================
    // cycle 2, error and new record
    // ================================================
    always_comb begin
        nxt_err = No_Err;
        nxt_rec = rec;
        keep1   = food_hit1 ? ctm_info_t'('0) : rec.d_man.ctm1;
        keep2   = food_hit2 ? ctm_info_t'('0) : rec.d_man.ctm2;
        case (action)
            Order: begin
                if (sum > sum_t'(rec.res.limit)) begin
                    nxt_err = Res_busy;
                end else begin
                    case (cmd.food_ser.food_id)
                        2'd1: nxt_rec.res.food1 = rec.res.food1 + 8'(cmd.food_ser.servings);
                        2'd2: nxt_rec.res.food2 = rec.res.food2 + 8'(cmd.food_ser.servings);
                        2'd3: nxt_rec.res.food3 = rec.res.food3 + 8'(cmd.food_ser.servings);
                        default: ;
                    endcase
                end
            end
            Deliver: begin
                if (rec.d_man == '0) begin
                    nxt_err = No_customers;
                end else begin
                    nxt_rec.d_man.ctm1 = rec.d_man.ctm2;
                    nxt_rec.d_man.ctm2 = '0;
                end
            end
            Cancel: begin
                if (rec.d_man == '0)
                    nxt_err = Wrong_cancel;
                else if (!res_hit1 && !res_hit2)
                    nxt_err = Wrong_res_ID;
                else if (!food_hit1 && !food_hit2)
                    nxt_err = Wrong_food_ID;
                else if (keep1 == '0) begin
                    // survivor in slot 2 moves up
                    nxt_rec.d_man.ctm1 = keep2;
                    nxt_rec.d_man.ctm2 = '0;
                end else begin
                    nxt_rec.d_man.ctm1 = keep1;
                    nxt_rec.d_man.ctm2 = keep2;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge inf_rst_n) begin
        if (!inf_rst_n)
            err <= No_Err;
        else if (stage1)
            err <= nxt_err;
    end

    always_ff @(posedge clk) begin
        if (stage1)
            new_rec <= nxt_rec;
    end

endmodule

/* verif/fd_checker.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_checker (
    input  logic                  clk,
    input  logic                  inf_rst_n,
    input  logic                  act_valid,
    input  logic                  id_valid,
    input  logic                  res_valid,
    input  logic                  food_valid,
    input  logic [`FD_BUS_W-1:0]  data_in,
    input  logic [`FD_ADDR_W-1:0] c_addr,
    input  logic [`FD_RAW_W-1:0]  c_data_w,
    input  logic                  c_in_valid,
    input  logic                  c_r_wb,
    input  logic [`FD_RAW_W-1:0]  c_data_r,
    input  logic                  c_out_valid,
    input  logic                  out_valid,
    input  logic                  complete,
    input  fd_cmd_pkg::err_e      err_msg,
    input  logic [`FD_RAW_W-1:0]  out_info
);
    import fd_cmd_pkg::*;

    string       test_name = "none";
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          err_cnt = 0;
    int          result_cnt = 0;
    logic        test_bad = 1'b0;
    logic        cmd_open = 1'b0;
    logic        read_seen = 1'b0;
    logic        write_seen = 1'b0;
    logic [1:0]  cur_act = 2'd3;
    logic [7:0]  cur_id = '0;
    logic [7:0]  cur_res = '0;
    logic [5:0]  cur_food = '0;
    err_e        exp_err = No_Err;
    logic [63:0] exp_word = '0;
    logic [63:0] exp_info = '0;

    // ==================================================
    // reference model, works on the stored DRAM layout
    // ==================================================
    function automatic void ref_model(input logic [1:0] act, input logic [7:0] res,
                                      input logic [5:0] food, input logic [63:0] raw,
                                      output err_e err, output logic [63:0] word,
                                      output logic [63:0] info);
        logic [7:0]  lim;
        logic [7:0]  f1;
        logic [7:0]  f2;
        logic [7:0]  f3;
        logic [15:0] c1;
        logic [15:0] c2;
        logic [9:0]  sum;
        logic        rh1;
        logic        rh2;
        logic        fh1;
        logic        fh2;
        lim = raw[7:0];
        f1  = raw[15:8];
        f2  = raw[23:16];
        f3  = raw[31:24];
        // customer bytes are stored swapped
        c1  = {raw[39:32], raw[47:40]};
        c2  = {raw[55:48], raw[63:56]};
        sum = 10'(f1) + 10'(f2) + 10'(f3) + 10'(food[3:0]);
        rh1 = (c1 != 16'h0) && (c1[13:6] == res);
        rh2 = (c2 != 16'h0) && (c2[13:6] == res);
        fh1 = rh1 && (c1[5:4] == food[5:4]);
        fh2 = rh2 && (c2[5:4] == food[5:4]);
        err = No_Err;
        if (act == Order) begin
            if (sum > 10'(lim))
                err = Res_busy;
            else if (food[5:4] == 2'd1)
                f1 = f1 + 8'(food[3:0]);
            else if (food[5:4] == 2'd2)
                f2 = f2 + 8'(food[3:0]);
            else if (food[5:4] == 2'd3)
                f3 = f3 + 8'(food[3:0]);
        end else if (act == Deliver) begin
            if (c1 == 16'h0 && c2 == 16'h0) begin
                err = No_customers;
            end else begin
                c1 = c2;
                c2 = 16'h0;
            end
        end else if (act == Cancel) begin
            if (c1 == 16'h0 && c2 == 16'h0) begin
                err = Wrong_cancel;
            end else if (!rh1 && !rh2) begin
                err = Wrong_res_ID;
            end else if (!fh1 && !fh2) begin
                err = Wrong_food_ID;
            end else begin
                if (fh1)
                    c1 = 16'h0;
                if (fh2)
                    c2 = 16'h0;
                // queue closes up
                if (c1 == 16'h0) begin
                    c1 = c2;
                    c2 = 16'h0;
                end
            end
        end
        word = {c2[7:0], c2[15:8], c1[7:0], c1[15:8], f3, f2, f1, lim};
        if (err != No_Err)
            info = '0;
        else if (act == Order)
            info = {32'h0, lim, f1, f2, f3};
        else
            info = {c1, c2, 32'h0};
    endfunction

    task automatic begin_test(input string name);
        test_name  = name;
        test_bad   = 1'b0;
        read_seen  = 1'b0;
        write_seen = 1'b0;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
            test_bad = 1'b1;
            err_cnt++;
        end
    endtask

    task automatic flag_error(input string text);
        $display("ERROR in %s: %s", test_name, text);
        test_bad = 1'b1;
        err_cnt++;
    endtask

    task automatic finish_test();
        if (test_bad) begin
            fail_cnt++;
            $display("done %s: failed", test_name);
        end else begin
            pass_cnt++;
            $display("done %s: ok", test_name);
        end
    endtask

    task automatic check_reset();
        begin_test("reset");
        check_value("out_valid", '0, out_valid);
        check_value("c_in_valid", '0, c_in_valid);
        check_value("complete", '0, complete);
        check_value("err_msg", No_Err, err_msg);
        finish_test();
    endtask

    // ==================================================
    // monitor, sampled mid cycle
    // ==================================================
    always @(negedge clk) begin
        if (inf_rst_n) begin
            if (act_valid) begin
                if (cmd_open)
                    flag_error("a new command started before the previous result");
                cmd_open = 1'b1;
                cur_act  = data_in[1:0];
            end
            if (id_valid)
                cur_id = data_in;
            if (res_valid)
                cur_res = data_in;
            if (food_valid)
                cur_food = data_in[5:0];
            if (c_in_valid) begin
                check_value("c_addr", (cur_act == Order) ? cur_res : cur_id, c_addr);
                if (!c_r_wb) begin
                    write_seen = 1'b1;
                    check_value("c_data_w", exp_word, c_data_w);
                end
            end
            if (c_out_valid && c_r_wb) begin
                read_seen = 1'b1;
                ref_model(cur_act, cur_res, cur_food, c_data_r, exp_err, exp_word, exp_info);
            end
            if (out_valid) begin
                result_cnt++;
                if (!cmd_open)
                    flag_error("out_valid pulsed with no command pending");
                if (!read_seen)
                    flag_error("the record was never read from DRAM");
                if (write_seen != (exp_err == No_Err))
                    flag_error("DRAM write does not agree with the result");
                cmd_open = 1'b0;
                check_value("err_msg", exp_err, err_msg);
                check_value("complete", exp_err == No_Err, complete);
                check_value("out_info", exp_info, out_info);
                finish_test();
            end else if (complete || err_msg != No_Err || out_info != '0) begin
                flag_error("result outputs are not zero while out_valid is low");
            end
        end
    end

endmodule

/* verif/fd_tb.sv */
`timescale 1ns/1ps
`include "fd_defs.svh"

module fd_tb;
    import fd_cmd_pkg::*;

    localparam int RESULT_TIMEOUT = 200;
    localparam int N_RANDOM = 40;
    localparam int K_ACT = 0;
    localparam int K_ID = 1;
    localparam int K_RES = 2;
    localparam int K_FOOD = 3;

    logic                  clk = 1'b0;
    logic                  inf_rst_n;
    logic                  act_valid;
    logic                  id_valid;
    logic                  res_valid;
    logic                  food_valid;
    logic [`FD_BUS_W-1:0]  data_in;
    logic [`FD_RAW_W-1:0]  c_data_r = '0;
    logic                  c_out_valid = 1'b0;
    logic [`FD_ADDR_W-1:0] c_addr;
    logic [`FD_RAW_W-1:0]  c_data_w;
    logic                  c_in_valid;
    logic                  c_r_wb;
    logic                  out_valid;
    logic                  complete;
    err_e                  err_msg;
    logic [`FD_RAW_W-1:0]  out_info;

    // DRAM model
    logic [`FD_RAW_W-1:0]  dram [0:255];
    int                    dram_wait = 0;
    logic                  dram_rd = 1'b1;
    logic [`FD_ADDR_W-1:0] dram_addr = '0;
    logic [`FD_RAW_W-1:0]  dram_wdata = '0;
    int                    n_cmds = 0;

    always #10 clk = ~clk;

    fd_top i_dut (.*);

    fd_checker i_checker (.*);

    // answers each request after 1 to 5 cycles
    always @(posedge clk) begin
        #2;
        c_out_valid = 1'b0;
        if (dram_wait != 0) begin
            dram_wait = dram_wait - 1;
            if (dram_wait == 0) begin
                c_out_valid = 1'b1;
                if (dram_rd)
                    c_data_r = dram[dram_addr];
                else
                    dram[dram_addr] = dram_wdata;
            end
        end
        if (c_in_valid) begin
            dram_rd    = c_r_wb;
            dram_addr  = c_addr;
            dram_wdata = c_data_w;
            dram_wait  = 1 + int'($urandom % 5);
        end
    end

    // stored layout, customer bytes swapped
    function automatic logic [63:0] make_raw(input logic [7:0] lim, f1, f2, f3,
                                             input logic [15:0] c1, c2);
        return {c2[7:0], c2[15:8], c1[7:0], c1[15:8], f3, f2, f1, lim};
    endfunction

    function automatic logic [15:0] ctm(input logic [7:0] res, input logic [1:0] food,
                                        input logic [3:0] ser);
        return {2'b01, res, food, ser};
    endfunction

    function automatic logic [15:0] rand_ctm();
        logic [15:0] c;
        c = {2'($urandom), 8'($urandom % 4), 2'($urandom), 4'($urandom)};
        if ($urandom % 4 == 0)
            c = '0;
        return c;
    endfunction

    task automatic send_byte(input int kind, input logic [7:0] value);
        @(posedge clk);
        #2;
        data_in    = value;
        act_valid  = (kind == K_ACT);
        id_valid   = (kind == K_ID);
        res_valid  = (kind == K_RES);
        food_valid = (kind == K_FOOD);
        @(posedge clk);
        #2;
        act_valid  = 1'b0;
        id_valid   = 1'b0;
        res_valid  = 1'b0;
        food_valid = 1'b0;
        data_in    = '0;
    endtask

    task automatic wait_result(input string name);
        int n;
        n = 0;
        while (!out_valid && n < RESULT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("timeout: %s got no out_valid within %0d cycles", name, RESULT_TIMEOUT);
            $display("tests passed: %0d, failed: %0d", i_checker.pass_cnt,
                     i_checker.fail_cnt + 1);
            $display("TEST FAIL");
            $finish;
        end
        @(posedge clk);
    endtask

    task automatic run_cmd(input string name, input logic [1:0] act,
                           input logic [7:0] id, res, food);
        i_checker.begin_test(name);
        send_byte(K_ACT, {6'd0, act});
        if (act == Order) begin
            send_byte(K_RES, res);
            send_byte(K_FOOD, food);
        end else if (act == Cancel) begin
            send_byte(K_RES, res);
            send_byte(K_FOOD, food);
            send_byte(K_ID, id);
        end else begin
            send_byte(K_ID, id);
        end
        wait_result(name);
        n_cmds++;
    endtask

    task automatic directed(input string name, input logic [63:0] raw, input logic [1:0] act,
                            input logic [7:0] id, res, food);
        dram[(act == Order) ? res : id] = raw;
        run_cmd(name, act, id, res, food);
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin : main
        int         i;
        logic [1:0] act;
        logic       ok;
        void'($urandom(34));
        inf_rst_n  = 1'b0;
        act_valid  = 1'b0;
        id_valid   = 1'b0;
        res_valid  = 1'b0;
        food_valid = 1'b0;
        data_in    = '0;
        // small food counts so orders land on both sides of the limit
        for (i = 0; i < 256; i++)
            dram[i] = make_raw(8'($urandom), 8'($urandom % 64), 8'($urandom % 64),
                               8'($urandom % 64), rand_ctm(), rand_ctm());
        repeat (4) @(posedge clk);
        #2 inf_rst_n = 1'b1;
        @(posedge clk);
        #5;
        i_checker.check_reset();

        directed("order_ok", make_raw(100, 10, 20, 30, 0, 0), Order, 0, 8'h10, {2'd2, 4'd5});
        directed("order_busy", make_raw(40, 10, 20, 30, 0, 0), Order, 0, 8'h11, {2'd1, 4'd3});
        directed("deliver_two", make_raw(1, 2, 3, 4, ctm(3, 1, 2), ctm(5, 2, 4)),
                 Deliver, 8'h20, 0, 0);
        directed("deliver_one", make_raw(1, 2, 3, 4, ctm(3, 1, 2), 0), Deliver, 8'h21, 0, 0);
        directed("deliver_empty", make_raw(9, 8, 7, 6, 0, 0), Deliver, 8'h22, 0, 0);
        directed("cancel_ctm1", make_raw(0, 0, 0, 0, ctm(7, 1, 1), ctm(8, 2, 1)),
                 Cancel, 8'h30, 7, {2'd1, 4'd0});
        directed("cancel_ctm2", make_raw(0, 0, 0, 0, ctm(7, 1, 1), ctm(8, 2, 1)),
                 Cancel, 8'h31, 8, {2'd2, 4'd0});
        directed("cancel_both", make_raw(0, 0, 0, 0, ctm(7, 1, 1), ctm(7, 1, 3)),
                 Cancel, 8'h32, 7, {2'd1, 4'd0});
        directed("cancel_empty", make_raw(5, 1, 1, 1, 0, 0), Cancel, 8'h33, 7, {2'd1, 4'd0});
        directed("cancel_res", make_raw(0, 0, 0, 0, ctm(7, 1, 1), 0),
                 Cancel, 8'h34, 9, {2'd1, 4'd0});
        directed("cancel_food", make_raw(0, 0, 0, 0, ctm(7, 1, 1), 0),
                 Cancel, 8'h35, 7, {2'd3, 4'd0});

        for (i = 0; i < N_RANDOM; i++) begin
            act = 2'($urandom % 3);
            run_cmd($sformatf("random_%0d", i), act, 8'($urandom),
                    (act == Cancel) ? 8'($urandom % 4) : 8'($urandom), 8'($urandom % 64));
        end

        // room for any stray pulse to show up
        repeat (10) @(negedge clk);
        ok = (i_checker.fail_cnt == 0) && (i_checker.err_cnt == 0);
        if (i_checker.result_cnt != n_cmds) begin
            $display("out_valid pulsed %0d times for %0d commands", i_checker.result_cnt,
                     n_cmds);
            ok = 1'b0;
        end
        $display("tests passed: %0d, failed: %0d", i_checker.pass_cnt, i_checker.fail_cnt);
        if (ok)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
